/* mpdma_axi_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI3 field widths and fixed burst fields for both masters
// Every access is one 32-bit beat with all strobes on
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mpdma_axi_pkg;

    localparam int axi_addr_w = 32;
    localparam int axi_data_w = 32;
    localparam int axi_id_w   = 4;
    localparam int axi_len_w  = 4;

    // Single beat bursts only
    localparam logic [axi_len_w-1:0]    axi_len_single = '0;
    localparam logic [2:0]              axi_size_word  = 3'd2;   // 4 bytes
    localparam logic [1:0]              axi_burst_incr = 2'b01;
    localparam logic [axi_data_w/8-1:0] axi_strb_all   = '1;

    typedef logic [axi_addr_w-1:0] axi_addr_t;
    typedef logic [axi_data_w-1:0] axi_data_t;

endpackage

/* mpdma_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Engine widths and matrix limits for the padding DMA
// Source width must be even, 2 to max_width
// Output is (width+2) square, written as 2x2 blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mpdma_pkg;

    localparam int dim_w   = 6;
    localparam int coord_w = 7;    // Output index reaches width+1

    localparam int max_width  = 62;
    localparam int pad_border = 1;   // Mirrored rows/cols per side

    localparam int words_per_block = 4;
    localparam int block_credits   = 2;   // Writer slots
    localparam int word_bytes      = 4;

    typedef logic [dim_w-1:0]   dim_t;
    typedef logic [coord_w-1:0] coord_t;

    // Bit 1 selects the row, bit 0 the column inside a block
    typedef enum logic [1:0] {
        corner_tl = 2'd0,
        corner_tr = 2'd1,
        corner_bl = 2'd2,
        corner_br = 2'd3
    } corner_t;

endpackage

/* mpdma_mirror_map.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output coordinate to mirrored source address, combinational
// Assumes width of at least 2 so the reflected index exists
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mpdma_mirror_map (
    input  mpdma_pkg::coord_t        out_row_i,
    input  mpdma_pkg::coord_t        out_col_i,
    input  mpdma_pkg::dim_t          width_i,
    input  mpdma_axi_pkg::axi_addr_t src_base_i,
    output mpdma_axi_pkg::axi_addr_t addr_o
);
    import mpdma_axi_pkg::*;
    import mpdma_pkg::*;

    coord_t      src_row;     // Zero-based after reflection
    coord_t      src_col;
    logic [15:0] word_off;

    // Returns the 1-based source index for one output index
    function automatic coord_t reflect(input coord_t k, input dim_t w);
        coord_t edge_hi;
        edge_hi = coord_t'(w) + coord_t'(pad_border);
        if (k == '0)
            return coord_t'(pad_border + 1);        // Top/left border
        else if (k == edge_hi)
            return coord_t'(w) - coord_t'(pad_border);
        else
            return k;
    endfunction

    always_comb begin
        src_row  = reflect(out_row_i, width_i) - coord_t'(1);
        src_col  = reflect(out_col_i, width_i) - coord_t'(1);
        word_off = 16'(src_row) * 16'(width_i) + 16'(src_col);
        addr_o   = src_base_i + axi_addr_t'(word_off) * axi_addr_t'(word_bytes);
    end

endmodule

/* mpdma_block_seq.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Run control. Config is sampled on start while idle
// done_o stays high after a run until start_i drops
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mpdma_block_seq (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start_i,
    input  mpdma_axi_pkg::axi_addr_t src_addr_i,
    input  mpdma_axi_pkg::axi_addr_t dst_addr_i,
    input  mpdma_pkg::dim_t          mat_width_i,
    output logic                     done_o,
    output mpdma_axi_pkg::axi_addr_t cfg_src_o,
    output mpdma_axi_pkg::axi_addr_t cfg_dst_o,
    output mpdma_pkg::dim_t          cfg_width_o,
    output logic                     blk_valid_o,
    output mpdma_pkg::coord_t        blk_row_o,
    output mpdma_pkg::coord_t        blk_col_o,
    input  logic                     blk_ready_i,
    input  logic                     blk_written_i
);
    import mpdma_pkg::*;

    typedef enum logic [1:0] {st_idle, st_issue, st_finish} state_t;

    state_t      state;
    dim_t        blk_side;      // Blocks per output row
    logic [10:0] blk_total;
    logic [10:0] written_cnt;
    logic        col_last;
    logic        row_last;

    assign blk_side  = {1'b0, cfg_width_o[dim_w-1:1]} + dim_t'(1);
    assign blk_total = 11'(blk_side) * 11'(blk_side);
    assign col_last  = (blk_col_o == coord_t'(cfg_width_o));
    assign row_last  = (blk_row_o == coord_t'(cfg_width_o));
    assign done_o    = (state != st_issue);

    always_ff @(posedge clk) begin
        if (state == st_idle && start_i) begin
            cfg_src_o   <= src_addr_i;
            cfg_dst_o   <= dst_addr_i;
            cfg_width_o <= mat_width_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= st_idle;
            blk_valid_o <= 1'b0;
            blk_row_o   <= '0;
            blk_col_o   <= '0;
            written_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start_i) begin
                        state       <= st_issue;
                        blk_valid_o <= 1'b1;
                        blk_row_o   <= '0;
                        blk_col_o   <= '0;
                        written_cnt <= '0;
                    end
                end
                st_issue: begin
                    if (blk_valid_o && blk_ready_i) begin
                        if (col_last && row_last) begin
                            blk_valid_o <= 1'b0;    // All positions handed out
                        end else if (col_last) begin
                            blk_col_o <= '0;
                            blk_row_o <= blk_row_o + coord_t'(2);
                        end else begin
                            blk_col_o <= blk_col_o + coord_t'(2);
                        end
                    end
                    if (blk_written_i) begin
                        written_cnt <= written_cnt + 11'd1;
                        if (written_cnt == blk_total - 11'd1)
                            state <= st_finish;
                    end
                end
                st_finish: begin
                    if (!start_i)
                        state <= st_idle;   // Wait for start to drop
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_width_legal: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_idle && start_i) |->
            (!mat_width_i[0] && mat_width_i >= dim_t'(2) && mat_width_i <= dim_t'(max_width)));

endmodule

/* mpdma_block_reader.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI read master, four single-beat reads per block
// One read outstanding. Hand-off waits for a writer credit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mpdma_block_reader (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mpdma_axi_pkg::axi_addr_t  cfg_src_i,
    input  mpdma_pkg::dim_t           cfg_width_i,
    input  logic                      blk_valid_i,
    input  mpdma_pkg::coord_t         blk_row_i,
    input  mpdma_pkg::coord_t         blk_col_i,
    output logic                      blk_ready_o,
    output logic                      arvalid_o,
    output mpdma_axi_pkg::axi_addr_t  araddr_o,
    input  logic                      arready_i,
    input  logic                      rvalid_i,
    input  mpdma_axi_pkg::axi_data_t  rdata_i,
    output logic                      rready_o,
    output logic                      wr_valid_o,
    output mpdma_pkg::coord_t         wr_row_o,
    output mpdma_pkg::coord_t         wr_col_o,
    output mpdma_axi_pkg::axi_data_t [mpdma_pkg::words_per_block-1:0] wr_data_o,
    input  logic                      credit_return_i
);
    import mpdma_axi_pkg::*;
    import mpdma_pkg::*;

    typedef enum logic [1:0] {rd_idle, rd_addr, rd_data, rd_hand} state_t;

    state_t  state;
    corner_t corner;
    coord_t  cur_row;
    coord_t  cur_col;
    logic [$clog2(block_credits+1)-1:0] credits;

    assign cur_row = wr_row_o + coord_t'(corner[1]);
    assign cur_col = wr_col_o + coord_t'(corner[0]);

    assign blk_ready_o = (state == rd_idle);
    assign arvalid_o   = (state == rd_addr);
    assign rready_o    = (state == rd_data);
    assign wr_valid_o  = (state == rd_hand) && (credits != '0);

    mpdma_mirror_map i_map (
        .out_row_i  (cur_row),
        .out_col_i  (cur_col),
        .width_i    (cfg_width_i),
        .src_base_i (cfg_src_i),
        .addr_o     (araddr_o)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= rd_idle;
            corner  <= corner_tl;
            credits <= block_credits[$bits(credits)-1:0];
        end else begin
            case (state)
                rd_idle: begin
                    if (blk_valid_i) begin
                        state  <= rd_addr;
                        corner <= corner_tl;
                    end
                end
                rd_addr: if (arready_i) state <= rd_data;
                rd_data: begin
                    if (rvalid_i) begin
                        if (corner == corner_br) begin
                            state <= rd_hand;
                        end else begin
                            corner <= corner_t'(corner + 2'd1);
                            state  <= rd_addr;
                        end
                    end
                end
                rd_hand: if (wr_valid_o) state <= rd_idle;
                default: state <= rd_idle;
            endcase

            // A hand-off and a returned credit can meet in one cycle
            if (wr_valid_o && !credit_return_i)
                credits <= credits - 1'b1;
            else if (!wr_valid_o && credit_return_i)
                credits <= credits + 1'b1;
        end
    end

    // Block position and read words
    always_ff @(posedge clk) begin
        if (state == rd_idle && blk_valid_i) begin
            wr_row_o <= blk_row_i;
            wr_col_o <= blk_col_i;
        end
        if (state == rd_data && rvalid_i)
            wr_data_o[corner] <= rdata_i;
    end

    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= block_credits[$bits(credits)-1:0]);

endmodule

/* mpdma_block_writer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-slot block store and AXI write master
// Words go out in corner order, one AW/W/B exchange each
// The reader must only send a block into a free slot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mpdma_block_writer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mpdma_axi_pkg::axi_addr_t  cfg_dst_i,
    input  mpdma_pkg::dim_t           cfg_width_i,
    input  logic                      wr_valid_i,
    input  mpdma_pkg::coord_t         wr_row_i,
    input  mpdma_pkg::coord_t         wr_col_i,
    input  mpdma_axi_pkg::axi_data_t [mpdma_pkg::words_per_block-1:0] wr_data_i,
    output logic                      awvalid_o,
    output mpdma_axi_pkg::axi_addr_t  awaddr_o,
    input  logic                      awready_i,
    output logic                      wvalid_o,
    output mpdma_axi_pkg::axi_data_t  wdata_o,
    output logic                      wlast_o,
    input  logic                      wready_i,
    input  logic                      bvalid_i,
    output logic                      bready_o,
    output logic                      blk_written_o
);
    import mpdma_axi_pkg::*;
    import mpdma_pkg::*;

    axi_data_t [words_per_block-1:0] slot_data [2];
    coord_t                          slot_row  [2];
    coord_t                          slot_col  [2];

    logic [1:0]  slot_full;
    logic        wp;          // Next slot to fill
    logic        rp;          // Slot being written out
    logic        busy;
    logic        aw_pend;
    logic        w_pend;
    corner_t     corner;
    coord_t      out_stride;
    coord_t      cur_row;
    coord_t      cur_col;
    logic [15:0] word_off;
    logic        b_hs;

    assign out_stride = coord_t'(cfg_width_i) + coord_t'(2 * pad_border);
    assign cur_row    = slot_row[rp] + coord_t'(corner[1]);
    assign cur_col    = slot_col[rp] + coord_t'(corner[0]);
    assign word_off   = 16'(cur_row) * 16'(out_stride) + 16'(cur_col);

    assign awvalid_o = aw_pend;
    assign awaddr_o  = cfg_dst_i + axi_addr_t'(word_off) * axi_addr_t'(word_bytes);
    assign wvalid_o  = w_pend;
    assign wdata_o   = slot_data[rp][corner];
    assign wlast_o   = w_pend;              // Every beat is the last
    assign bready_o  = busy;
    assign b_hs      = bvalid_i && bready_o;

    assign blk_written_o = b_hs && (corner == corner_br);

    always_ff @(posedge clk) begin
        if (wr_valid_i) begin
            slot_data[wp] <= wr_data_i;
            slot_row[wp]  <= wr_row_i;
            slot_col[wp]  <= wr_col_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_full <= '0;
            wp        <= 1'b0;
            rp        <= 1'b0;
            busy      <= 1'b0;
            aw_pend   <= 1'b0;
            w_pend    <= 1'b0;
            corner    <= corner_tl;
        end else begin
            if (wr_valid_i) begin
                slot_full[wp] <= 1'b1;
                wp            <= ~wp;
            end
            if (!busy) begin
                if (slot_full[rp]) begin    // Start the first word
                    busy    <= 1'b1;
                    aw_pend <= 1'b1;
                    w_pend  <= 1'b1;
                    corner  <= corner_tl;
                end
            end else begin
                if (awready_i) aw_pend <= 1'b0;
                if (wready_i)  w_pend  <= 1'b0;
                if (b_hs) begin
                    if (corner == corner_br) begin
                        busy          <= 1'b0;
                        slot_full[rp] <= 1'b0;
                        rp            <= ~rp;
                    end else begin
                        corner  <= corner_t'(corner + 2'd1);
                        aw_pend <= 1'b1;
                        w_pend  <= 1'b1;
                    end
                end
            end
        end
    end

    // Credits keep the ring from overflowing
    a_slot_free: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid_i |-> !(&slot_full));

endmodule

/* mpdma_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mirror-padding DMA top. AXI3 master, single-beat accesses
// IDs are fixed at 0 and bresp/rresp are not checked
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mpdma_top (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    start_i,
    input  mpdma_axi_pkg::axi_addr_t                src_addr_i,
    input  mpdma_axi_pkg::axi_addr_t                dst_addr_i,
    input  mpdma_pkg::dim_t                         mat_width_i,
    output logic                                    done_o,
    // AW channel
    output logic [mpdma_axi_pkg::axi_id_w-1:0]      awid_o,
    output mpdma_axi_pkg::axi_addr_t                awaddr_o,
    output logic [mpdma_axi_pkg::axi_len_w-1:0]     awlen_o,
    output logic [2:0]                              awsize_o,
    output logic [1:0]                              awburst_o,
    output logic                                    awvalid_o,
    input  logic                                    awready_i,
    // W channel
    output logic [mpdma_axi_pkg::axi_id_w-1:0]      wid_o,
    output mpdma_axi_pkg::axi_data_t                wdata_o,
    output logic [mpdma_axi_pkg::axi_data_w/8-1:0]  wstrb_o,
    output logic                                    wlast_o,
    output logic                                    wvalid_o,
    input  logic                                    wready_i,
    // B channel
    input  logic [mpdma_axi_pkg::axi_id_w-1:0]      bid_i,
    input  logic [1:0]                              bresp_i,
    input  logic                                    bvalid_i,
    output logic                                    bready_o,
    // AR channel
    output logic [mpdma_axi_pkg::axi_id_w-1:0]      arid_o,
    output mpdma_axi_pkg::axi_addr_t                araddr_o,
    output logic [mpdma_axi_pkg::axi_len_w-1:0]     arlen_o,
    output logic [2:0]                              arsize_o,
    output logic [1:0]                              arburst_o,
    output logic                                    arvalid_o,
    input  logic                                    arready_i,
    // R channel
    input  logic [mpdma_axi_pkg::axi_id_w-1:0]      rid_i,
    input  mpdma_axi_pkg::axi_data_t                rdata_i,
    input  logic [1:0]                              rresp_i,
    input  logic                                    rlast_i,
    input  logic                                    rvalid_i,
    output logic                                    rready_o
);
    import mpdma_axi_pkg::*;
    import mpdma_pkg::*;

    axi_addr_t cfg_src;
    axi_addr_t cfg_dst;
    dim_t      cfg_width;
    logic      blk_valid;
    logic      blk_ready;
    coord_t    blk_row;
    coord_t    blk_col;
    logic      wr_valid;
    coord_t    wr_row;
    coord_t    wr_col;
    axi_data_t [words_per_block-1:0] wr_data;
    logic      blk_written;

    // Fixed single-beat burst fields
    assign awid_o    = '0;
    assign awlen_o   = axi_len_single;
    assign awsize_o  = axi_size_word;
    assign awburst_o = axi_burst_incr;
    assign wid_o     = '0;
    assign wstrb_o   = axi_strb_all;
    assign arid_o    = '0;
    assign arlen_o   = axi_len_single;
    assign arsize_o  = axi_size_word;
    assign arburst_o = axi_burst_incr;

    mpdma_block_seq i_seq (
        .clk, .rst_n, .start_i, .src_addr_i, .dst_addr_i, .mat_width_i, .done_o,
        .cfg_src_o     (cfg_src),
        .cfg_dst_o     (cfg_dst),
        .cfg_width_o   (cfg_width),
        .blk_valid_o   (blk_valid),
        .blk_row_o     (blk_row),
        .blk_col_o     (blk_col),
        .blk_ready_i   (blk_ready),
        .blk_written_i (blk_written)
    );

    mpdma_block_reader i_reader (
        .clk, .rst_n, .arvalid_o, .araddr_o, .arready_i, .rvalid_i, .rdata_i, .rready_o,
        .cfg_src_i       (cfg_src),
        .cfg_width_i     (cfg_width),
        .blk_valid_i     (blk_valid),
        .blk_row_i       (blk_row),
        .blk_col_i       (blk_col),
        .blk_ready_o     (blk_ready),
        .wr_valid_o      (wr_valid),
        .wr_row_o        (wr_row),
        .wr_col_o        (wr_col),
        .wr_data_o       (wr_data),
        .credit_return_i (blk_written)   // One credit per finished block
    );

    mpdma_block_writer i_writer (
        .clk, .rst_n, .awvalid_o, .awaddr_o, .awready_i, .wvalid_o, .wdata_o, .wlast_o,
        .wready_i, .bvalid_i, .bready_o,
        .cfg_dst_i     (cfg_dst),
        .cfg_width_i   (cfg_width),
        .wr_valid_i    (wr_valid),
        .wr_row_i      (wr_row),
        .wr_col_i      (wr_col),
        .wr_data_i     (wr_data),
        .blk_written_o (blk_written)
    );

endmodule

/* tb_mpdma.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for mpdma_top with a single-beat AXI memory model
// Memory is 4096 words from address 0. Waits on the AXI
// channels come from a Galois LFSR in the random tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_mpdma;

    localparam int mem_words   = 4096;
    localparam int max_dly     = 3;      // Two LFSR bits per wait
    localparam int hold_cycles = 4;
    localparam int total_words = 6*6 + 8*8 + 4*4 + 10*10;
    localparam int cycle_limit = total_words * 4 * (max_dly + 2) + 400;

    bit          clk;
    logic        rst_n, start_i, done_o;
    logic [31:0] src_addr_i, dst_addr_i;
    logic [5:0]  mat_width_i;
    logic [3:0]  awid_o, awlen_o, wid_o, bid_i, arid_o, arlen_o, rid_i;
    logic [31:0] awaddr_o, wdata_o, araddr_o, rdata_i;
    logic [2:0]  awsize_o, arsize_o;
    logic [1:0]  awburst_o, arburst_o, bresp_i, rresp_i;
    logic [3:0]  wstrb_o;
    logic        awvalid_o, awready_i, wlast_o, wvalid_o, wready_i;
    logic        bvalid_i, bready_o, arvalid_o, arready_i;
    logic        rlast_i, rvalid_i, rready_o;

    logic [31:0] mem [mem_words];
    logic [15:0] lfsr_state = 16'd74;

    // Memory model state carried across runs
    int          ar_dly = 0, r_dly = 0, aw_dly = 0, w_dly = 0, b_dly = 0;
    bit          r_busy = 1'b0, aw_got = 1'b0, w_got = 1'b0;
    logic [31:0] r_addr, aw_addr, w_data;
    int          wr_seen = 0;
    int          cycle_cnt = 0;

    // Current test
    string       test_name;
    int          cur_run, cur_w;
    logic [31:0] cur_src, cur_dst, src_hi;
    bit          rand_en = 1'b0;
    bit          cmp_req = 1'b0, cmp_ack = 1'b0;

    mpdma_top i_dut (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    function automatic int take_bits(input int n);
        int val;
        int i;
        val = 0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);     // One step per bit
            val = (val << 1) | int'(lfsr_state[0]);
        end
        return val;
    endfunction

    function automatic int next_delay();
        if (rand_en)
            return take_bits(2);
        return 0;
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return 32'hF000_0000 | (32'(idx) << 12) | 32'(idx);
    endfunction

    // Source element at 1-based row r, column c
    function automatic logic [31:0] src_word(input int run, input int r, input int c);
        return {8'h5A, 8'(run), 8'(r), 8'(c)};
    endfunction

    // Index 0 reflects to 2 and w+1 to w-1 while the rest map to themselves
    function automatic int mirror_index(input int k, input int w);
        if (k == 0)
            return 2;
        if (k == w + 1)
            return w - 1;
        return k;
    endfunction

    function automatic logic [31:0] pad_ref(input int run, input int r, input int c,
                                            input int w);
        return src_word(run, mirror_index(r, w), mirror_index(c, w));
    endfunction

    task automatic load_memory(input int run, input logic [31:0] src, input int w);
        int i;
        int r;
        int c;
        for (i = 0; i < mem_words; i++)
            mem[i] = fill_word(i);
        for (r = 1; r <= w; r++)
            for (c = 1; c <= w; c++)
                mem[int'(src >> 2) + (r - 1) * w + (c - 1)] = src_word(run, r, c);
    endtask

    task automatic check_out_word(input int r, input int c, input logic [31:0] exp);
        logic [31:0] got;
        got = mem[int'(cur_dst >> 2) + r * (cur_w + 2) + c];
        assert (got === exp) else
            stop_on_error($sformatf("error %s word (%0d,%0d): expected %h, actual %h",
                                    test_name, r, c, exp, got));
    endtask

    // AXI slave model that decides at the falling edge what the next rising edge sees
    always @(negedge clk) begin
        rvalid_i = 1'b0;            // R before AR so data never leads its address
        if (r_busy) begin
            if (r_dly == 0) begin
                rvalid_i = 1'b1;
                rdata_i  = mem[r_addr[13:2]];
                if (rready_o)
                    r_busy = 1'b0;
            end else begin
                r_dly--;
            end
        end
        arready_i = 1'b0;
        if (arvalid_o && !r_busy) begin
            if (ar_dly == 0) begin
                // ID, length, size and burst type of a single INCR word
                assert (arid_o == 4'd0 && arlen_o == 4'd0 && arsize_o == 3'd2
                        && arburst_o == 2'd1) else
                    stop_on_error($sformatf(
                        "error %s AR fields: expected 0/0/2/1, actual %0d/%0d/%0d/%0d",
                        test_name, arid_o, arlen_o, arsize_o, arburst_o));
                assert (araddr_o[1:0] == 2'b00 && araddr_o >= cur_src && araddr_o < src_hi)
                    else stop_on_error($sformatf("%s: AR address %h unaligned or outside source",
                                                 test_name, araddr_o));
                arready_i = 1'b1;
                r_busy    = 1'b1;
                r_addr    = araddr_o;
                r_dly     = next_delay();
                ar_dly    = next_delay();
            end else begin
                ar_dly--;
            end
        end
        bvalid_i = 1'b0;            // B only after both AW and W went through
        if (aw_got && w_got) begin
            if (b_dly == 0) begin
                bvalid_i = 1'b1;
                if (bready_o) begin
                    mem[aw_addr[13:2]] = w_data;
                    wr_seen++;
                    aw_got = 1'b0;
                    w_got  = 1'b0;
                    b_dly  = next_delay();
                end
            end else begin
                b_dly--;
            end
        end
        awready_i = 1'b0;
        if (awvalid_o && !aw_got) begin
            if (aw_dly == 0) begin
                assert (awid_o == 4'd0 && awlen_o == 4'd0 && awsize_o == 3'd2
                        && awburst_o == 2'd1) else
                    stop_on_error($sformatf(
                        "error %s AW fields: expected 0/0/2/1, actual %0d/%0d/%0d/%0d",
                        test_name, awid_o, awlen_o, awsize_o, awburst_o));
                assert (awaddr_o[1:0] == 2'b00 && awaddr_o < 32'(mem_words * 4)) else
                    stop_on_error($sformatf("%s: AW address %h unaligned or outside memory",
                                            test_name, awaddr_o));
                awready_i = 1'b1;
                aw_got    = 1'b1;
                aw_addr   = awaddr_o;
                aw_dly    = next_delay();
            end else begin
                aw_dly--;
            end
        end
        wready_i = 1'b0;
        if (wvalid_o && !w_got) begin
            if (w_dly == 0) begin
                // ID, strobe and last flag of a full single beat
                assert (wid_o == 4'd0 && wstrb_o == 4'hF && wlast_o) else
                    stop_on_error($sformatf(
                        "error %s W fields: expected 0/f/1, actual %0d/%h/%0b",
                        test_name, wid_o, wstrb_o, wlast_o));
                wready_i = 1'b1;
                w_got    = 1'b1;
                w_data   = wdata_o;
                w_dly    = next_delay();
            end else begin
                w_dly--;
            end
        end
    end

    // Compare process that reads back the destination after done
    always begin
        int r;
        int c;
        int base;
        int last;
        wait (cmp_req);
        cmp_req = 1'b0;
        for (r = 0; r < cur_w + 2; r++)
            for (c = 0; c < cur_w + 2; c++)
                check_out_word(r, c, pad_ref(cur_run, r, c, cur_w));
        base = int'(cur_dst >> 2);
        last = base + (cur_w + 2) * (cur_w + 2);
        assert (mem[base - 1] === fill_word(base - 1)) else
            stop_on_error($sformatf("error %s word below area: expected %h, actual %h",
                                    test_name, fill_word(base - 1), mem[base - 1]));
        assert (mem[last] === fill_word(last)) else
            stop_on_error($sformatf("error %s word above area: expected %h, actual %h",
                                    test_name, fill_word(last), mem[last]));
        cmp_ack = 1'b1;
    end

    task automatic run_dma(input string name, input int run, input logic [31:0] src,
                           input logic [31:0] dst, input int w, input bit rnd);
        test_name = name;
        cur_run   = run;
        cur_src   = src;
        cur_dst   = dst;
        cur_w     = w;
        src_hi    = src + 32'(w * w * 4);
        rand_en   = rnd;
        load_memory(run, src, w);
        wr_seen = 0;
        @(negedge clk);
        src_addr_i  = src;
        dst_addr_i  = dst;
        mat_width_i = 6'(w);
        start_i     = 1'b1;
        @(negedge clk);
        assert (!done_o) else
            stop_on_error($sformatf("%s: done_o did not fall the cycle after start", name));
        while (!done_o)
            @(negedge clk);
        assert (wr_seen == (w + 2) * (w + 2)) else
            stop_on_error($sformatf("error %s write count: expected %0d, actual %0d",
                                    name, (w + 2) * (w + 2), wr_seen));
        repeat (hold_cycles) begin      // A held start must not restart the engine
            @(negedge clk);
            assert (done_o) else
                stop_on_error($sformatf("%s: done_o fell while start_i was still held", name));
        end
        start_i = 1'b0;
        @(negedge clk);
        assert (done_o) else
            stop_on_error($sformatf("%s: done_o fell after start_i was released", name));
        cmp_req = 1'b1;
        wait (cmp_ack);
        cmp_ack = 1'b0;
    endtask

    initial begin
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        stop_on_error($sformatf("timeout: tests did not finish within %0d cycles",
                                cycle_limit));
    end

    initial begin
        rst_n       = 1'b0;
        start_i     = 1'b0;
        src_addr_i  = '0;
        dst_addr_i  = '0;
        mat_width_i = '0;
        awready_i   = 1'b0;
        wready_i    = 1'b0;
        bvalid_i    = 1'b0;
        bid_i       = '0;
        bresp_i     = '0;
        arready_i   = 1'b0;
        rvalid_i    = 1'b0;
        rdata_i     = '0;
        rid_i       = '0;
        rresp_i     = '0;
        rlast_i     = 1'b1;     // Every beat is the last
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (done_o) else stop_on_error("done_o is low after reset");
        assert (!arvalid_o && !rready_o && !awvalid_o && !wvalid_o && !bready_o) else
            stop_on_error("an AXI valid or ready output is high after reset");

        run_dma("w4_nodelay", 1, 32'h0000_0100, 32'h0000_1000, 4, 1'b0);
        check_out_word(0, 0, src_word(1, 2, 2));    // Corners from the inner 2x2
        check_out_word(0, 5, src_word(1, 2, 3));
        check_out_word(5, 0, src_word(1, 3, 2));
        check_out_word(5, 5, src_word(1, 3, 3));
        run_dma("w6_backpressure", 2, 32'h0000_0200, 32'h0000_2000, 6, 1'b1);
        run_dma("w2_minimum", 3, 32'h0000_0400, 32'h0000_3000, 2, 1'b1);
        run_dma("w8_moved", 4, 32'h0000_0800, 32'h0000_3800, 8, 1'b1);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* all.f */
mpdma_axi_pkg.sv
mpdma_pkg.sv
mpdma_mirror_map.sv
mpdma_block_seq.sv
mpdma_block_reader.sv
mpdma_block_writer.sv
mpdma_top.sv
tb_mpdma.sv

/* Makefile */
# Verilator build and run for the mirror-padding DMA testbench
VERILATOR ?= verilator
TOP       ?= tb_mpdma
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** PASSED ***

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
